/* rtl/pmu_pkg.sv */
/*
 * Shared definitions of the performance monitoring unit
 * Sizes, register memory map and configuration bit positions
 * Typedefs for words, vectors, counter bank and crossbar selects
 * Self-test mode enum and the register, config and counter write structs
 */

`default_nettype none

package pmu_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int unsigned REG_WIDTH  = 32;
    localparam int unsigned N_COUNTERS = 8;
    localparam int unsigned N_SOC_EV   = 32;
    localparam int unsigned N_REGS     = 15;

    // One select field picks one of the SoC events
    localparam int unsigned XBAR_SEL_W  = $clog2(N_SOC_EV);
    localparam int unsigned XBAR_CFG_W  = N_COUNTERS * XBAR_SEL_W;
    // Select fields are packed across as many words as needed
    localparam int unsigned N_XBAR_REGS = (XBAR_CFG_W - 1) / REG_WIDTH + 1;

    localparam int unsigned ADDR_W    = $clog2(N_REGS);
    localparam int unsigned CNT_IDX_W = $clog2(N_COUNTERS);
    // Sum of all counters never overflows with these extra bits
    localparam int unsigned SUM_W     = REG_WIDTH + $clog2(N_COUNTERS);

    // ------------------------------------------------------------
    // Memory map
    // ------------------------------------------------------------
    localparam int unsigned ADDR_CFG         = 0;
    localparam int unsigned ADDR_CNT_BASE    = 1;
    localparam int unsigned ADDR_OVF_MASK    = ADDR_CNT_BASE + N_COUNTERS;
    // Read only, writes are dropped
    localparam int unsigned ADDR_OVF_VECT    = ADDR_OVF_MASK + 1;
    localparam int unsigned ADDR_QUOTA_MASK  = ADDR_OVF_VECT + 1;
    localparam int unsigned ADDR_QUOTA_LIMIT = ADDR_QUOTA_MASK + 1;
    localparam int unsigned ADDR_XBAR_BASE   = ADDR_QUOTA_LIMIT + 1;

    // Configuration word bits
    localparam int unsigned CFG_CNT_EN_BIT        = 0;
    localparam int unsigned CFG_CNT_SOFTRST_BIT   = 1;
    localparam int unsigned CFG_OVF_EN_BIT        = 2;
    localparam int unsigned CFG_OVF_SOFTRST_BIT   = 3;
    localparam int unsigned CFG_QUOTA_SOFTRST_BIT = 4;
    // Two bit self-test field
    localparam int unsigned CFG_SELFTEST_LSB      = 30;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef logic [REG_WIDTH-1:0]  pmu_word_t;
    typedef logic [ADDR_W-1:0]     pmu_addr_t;
    typedef logic [N_SOC_EV-1:0]   pmu_events_t;
    typedef logic [N_COUNTERS-1:0] pmu_cnt_vec_t;
    typedef logic [CNT_IDX_W-1:0]  pmu_cnt_idx_t;
    typedef logic [XBAR_SEL_W-1:0] xbar_sel_t;
    typedef logic [SUM_W-1:0]      pmu_sum_t;

    // Counter k sits at index k
    typedef pmu_word_t [N_COUNTERS-1:0] pmu_cnt_bank_t;
    // Field k starts at bit XBAR_SEL_W*k of the concatenated crossbar words
    typedef xbar_sel_t [N_COUNTERS-1:0] xbar_cfg_t;

    typedef enum logic [1:0] {
        ST_OFF     = 2'd0,
        ST_ALL_ON  = 2'd1,
        ST_ALL_OFF = 2'd2,
        ST_ONE_ON  = 2'd3
    } selftest_e;

    // One host write, applied on the next edge
    typedef struct packed {
        logic      we;
        pmu_addr_t addr;
        pmu_word_t data;
    } pmu_reg_wr_t;

    // Decoded configuration word
    typedef struct packed {
        selftest_e selftest;
        logic      cnt_en;
        logic      cnt_softrst;
        logic      ovf_en;
        logic      ovf_softrst;
        logic      quota_softrst;
    } pmu_cfg_t;

    // Software write targeting one counter
    typedef struct packed {
        logic         valid;
        pmu_cnt_idx_t idx;
        pmu_word_t    data;
    } pmu_cnt_wr_t;

endpackage

`default_nettype wire

/* rtl/pmu_regbank.sv */
/*
 * Register bank of the monitoring unit
 * Stores configuration, masks, quota limit and crossbar words
 * Turns counter address writes into counter write requests
 * Combinational read port over the whole memory map
 */

`default_nettype none

module pmu_regbank import pmu_pkg::*; (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire pmu_reg_wr_t   reg_wr_i,
    input  wire pmu_addr_t     rd_addr_i,
    input  wire pmu_cnt_bank_t counts_i,
    input  wire pmu_cnt_vec_t  ovf_vect_i,
    output pmu_word_t          rd_data_o,
    output pmu_cfg_t           cfg_o,
    output xbar_cfg_t          xbar_cfg_o,
    output pmu_cnt_wr_t        cnt_wr_o,
    output pmu_cnt_vec_t       ovf_mask_o,
    output pmu_cnt_vec_t       quota_mask_o,
    output pmu_word_t          quota_limit_o
);

    // Stored words
    pmu_word_t                          cfg_q;
    pmu_word_t                          ovf_mask_q;
    pmu_word_t                          quota_mask_q;
    pmu_word_t                          quota_limit_q;
    logic [N_XBAR_REGS*REG_WIDTH-1:0]   xbar_q;

    // Address decode of the read and write ports
    logic wr_cnt_hit;
    logic rd_cnt_hit;

    assign wr_cnt_hit = (reg_wr_i.addr >= ADDR_CNT_BASE)
                     && (reg_wr_i.addr < ADDR_CNT_BASE + N_COUNTERS);
    assign rd_cnt_hit = (rd_addr_i >= ADDR_CNT_BASE)
                     && (rd_addr_i < ADDR_CNT_BASE + N_COUNTERS);

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            xbar_q        <= '0;
        end else if (reg_wr_i.we) begin
            case (reg_wr_i.addr)
                ADDR_CFG:         cfg_q         <= reg_wr_i.data;
                ADDR_OVF_MASK:    ovf_mask_q    <= reg_wr_i.data;
                ADDR_QUOTA_MASK:  quota_mask_q  <= reg_wr_i.data;
                ADDR_QUOTA_LIMIT: quota_limit_q <= reg_wr_i.data;
                default: ;
            endcase
            // Crossbar words follow each other
            for (int i = 0; i < N_XBAR_REGS; i++) begin
                if (reg_wr_i.addr == ADDR_XBAR_BASE + i) begin
                    xbar_q[REG_WIDTH*i +: REG_WIDTH] <= reg_wr_i.data;
                end
            end
        end
    end

    // Counter writes go straight to the counters, which latch them on the edge
    assign cnt_wr_o.valid = reg_wr_i.we && wr_cnt_hit;
    assign cnt_wr_o.idx   = pmu_cnt_idx_t'(reg_wr_i.addr - ADDR_CNT_BASE);
    assign cnt_wr_o.data  = reg_wr_i.data;

    // ------------------------------------------------------------
    // Field unpacking
    // ------------------------------------------------------------
    assign cfg_o.selftest      = selftest_e'(cfg_q[CFG_SELFTEST_LSB +: 2]);
    assign cfg_o.cnt_en        = cfg_q[CFG_CNT_EN_BIT];
    assign cfg_o.cnt_softrst   = cfg_q[CFG_CNT_SOFTRST_BIT];
    assign cfg_o.ovf_en        = cfg_q[CFG_OVF_EN_BIT];
    assign cfg_o.ovf_softrst   = cfg_q[CFG_OVF_SOFTRST_BIT];
    assign cfg_o.quota_softrst = cfg_q[CFG_QUOTA_SOFTRST_BIT];

    // Only the low bits of the mask words drive logic
    assign ovf_mask_o    = ovf_mask_q[N_COUNTERS-1:0];
    assign quota_mask_o  = quota_mask_q[N_COUNTERS-1:0];
    assign quota_limit_o = quota_limit_q;

    // Upper bits of the last crossbar word are spare
    assign xbar_cfg_o = xbar_q[XBAR_CFG_W-1:0];

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    always_comb begin
        rd_data_o = '0;
        case (rd_addr_i)
            ADDR_CFG:         rd_data_o = cfg_q;
            ADDR_OVF_MASK:    rd_data_o = ovf_mask_q;
            ADDR_OVF_VECT:    rd_data_o = {{(REG_WIDTH-N_COUNTERS){1'b0}}, ovf_vect_i};
            ADDR_QUOTA_MASK:  rd_data_o = quota_mask_q;
            ADDR_QUOTA_LIMIT: rd_data_o = quota_limit_q;
            default: ;
        endcase
        if (rd_cnt_hit) begin
            rd_data_o = counts_i[pmu_cnt_idx_t'(rd_addr_i - ADDR_CNT_BASE)];
        end
        for (int i = 0; i < N_XBAR_REGS; i++) begin
            if (rd_addr_i == ADDR_XBAR_BASE + i) begin
                rd_data_o = xbar_q[REG_WIDTH*i +: REG_WIDTH];
            end
        end
    end

    // Vector address is read only, stored words must hold across such a write
    a_ovf_vect_ro: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (reg_wr_i.we && reg_wr_i.addr == ADDR_OVF_VECT)
        |=> $stable({cfg_q, ovf_mask_q, quota_mask_q, quota_limit_q, xbar_q}));

endmodule

`default_nettype wire

/* rtl/pmu_event_xbar.sv */
/*
 * Event crossbar with self-test override
 * Registers one selected SoC event per counter
 */

`default_nettype none

module pmu_event_xbar import pmu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire pmu_events_t events_i,
    input  wire xbar_cfg_t   xbar_cfg_i,
    input  wire selftest_e   selftest_i,
    output pmu_cnt_vec_t     cnt_events_o
);

    // Registered crossbar output, one cycle behind events_i
    pmu_cnt_vec_t xbar_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            xbar_q <= '0;
        end else begin
            // Output k takes the event named by select field k
            for (int k = 0; k < N_COUNTERS; k++) begin
                xbar_q[k] <= events_i[xbar_cfg_i[k]];
            end
        end
    end

    // ------------------------------------------------------------
    // Self-test patterns bypass the crossbar
    // ------------------------------------------------------------
    always_comb begin
        case (selftest_i)
            ST_ALL_ON:  cnt_events_o = '1;
            ST_ALL_OFF: cnt_events_o = '0;
            // Only counter 0 sees an event
            ST_ONE_ON:  cnt_events_o = pmu_cnt_vec_t'(1);
            default:    cnt_events_o = xbar_q;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/pmu_counters.sv */
/*
 * Bank of event counters
 * Soft reset, software write and increment, in that order of precedence
 * Wrap flag per counter for increments out of all-ones
 */

`default_nettype none

module pmu_counters import pmu_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rstn_i,
    input  wire logic         en_i,
    input  wire logic         softrst_i,
    input  wire pmu_cnt_wr_t  cnt_wr_i,
    input  wire pmu_cnt_vec_t cnt_events_i,
    output pmu_cnt_bank_t     counts_o,
    output pmu_cnt_vec_t      wrap_o
);

    pmu_cnt_bank_t cnt_q;
    // Per counter write select and increment request
    pmu_cnt_vec_t  wr_hit;
    pmu_cnt_vec_t  inc;

    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            wr_hit[k] = cnt_wr_i.valid && (cnt_wr_i.idx == k);
            inc[k]    = en_i && cnt_events_i[k];
            // Wrap only when the increment actually wins this edge
            wrap_o[k] = inc[k] && !softrst_i && !wr_hit[k] && (&cnt_q[k]);
        end
    end

    // ------------------------------------------------------------
    // Counter update
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                if (softrst_i) begin
                    cnt_q[k] <= '0;
                end else if (wr_hit[k]) begin
                    cnt_q[k] <= cnt_wr_i.data;
                end else if (inc[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    assign counts_o = cnt_q;

    // Soft reset empties the whole bank by the next cycle
    a_softrst_clears: assert property (@(posedge clk_i) disable iff (!rstn_i)
        softrst_i |=> (counts_o == '0));

endmodule

`default_nettype wire

/* rtl/pmu_interrupts.sv */
/*
 * Overflow and quota interrupts
 * Sticky masked overflow vector with its OR as interrupt
 * Sum of masked counters against the quota limit with a sticky flag
 */

`default_nettype none

module pmu_interrupts import pmu_pkg::*; (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire pmu_cnt_bank_t counts_i,
    input  wire pmu_cnt_vec_t  wrap_i,
    input  wire logic          ovf_en_i,
    input  wire logic          ovf_softrst_i,
    input  wire pmu_cnt_vec_t  ovf_mask_i,
    input  wire logic          quota_softrst_i,
    input  wire pmu_cnt_vec_t  quota_mask_i,
    input  wire pmu_word_t     quota_limit_i,
    output pmu_cnt_vec_t       ovf_vect_o,
    output logic               intr_overflow_o,
    output logic               intr_quota_o
);

    // ------------------------------------------------------------
    // Overflow
    // ------------------------------------------------------------
    pmu_cnt_vec_t ovf_vect_q;
    pmu_cnt_vec_t ovf_vect_d;
    logic         ovf_intr_q;

    // Soft reset wins over new wraps
    always_comb begin
        if (ovf_softrst_i) begin
            ovf_vect_d = '0;
        end else if (ovf_en_i) begin
            ovf_vect_d = ovf_vect_q | (wrap_i & ovf_mask_i);
        end else begin
            ovf_vect_d = ovf_vect_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_vect_q <= '0;
            ovf_intr_q <= 1'b0;
        end else begin
            ovf_vect_q <= ovf_vect_d;
            // Interrupt is registered from the next vector so both move together
            ovf_intr_q <= |ovf_vect_d;
        end
    end

    assign ovf_vect_o      = ovf_vect_q;
    assign intr_overflow_o = ovf_intr_q;

    // ------------------------------------------------------------
    // Quota
    // ------------------------------------------------------------
    pmu_sum_t quota_sum;
    logic     quota_exceed;
    logic     quota_intr_q;

    // Add up only the counters selected by the mask
    always_comb begin
        quota_sum = '0;
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (quota_mask_i[k]) begin
                quota_sum = quota_sum + pmu_sum_t'(counts_i[k]);
            end
        end
    end

    assign quota_exceed = quota_sum > pmu_sum_t'(quota_limit_i);

    // Sticky until software clears it
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            quota_intr_q <= 1'b0;
        end else if (quota_softrst_i) begin
            quota_intr_q <= 1'b0;
        end else if (quota_exceed) begin
            quota_intr_q <= 1'b1;
        end
    end

    assign intr_quota_o = quota_intr_q;

    // Registered interrupt and sticky vector stay in step
    a_ovf_intr_or: assert property (@(posedge clk_i) disable iff (!rstn_i)
        intr_overflow_o == (|ovf_vect_o));

endmodule

`default_nettype wire

/* rtl/pmu_top.sv */
/*
 * Top of the performance monitoring unit
 * Register bank, event crossbar, counters and interrupts
 */

`default_nettype none

module pmu_top import pmu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire pmu_reg_wr_t reg_wr_i,
    input  wire pmu_addr_t   rd_addr_i,
    input  wire pmu_events_t events_i,
    output pmu_word_t        rd_data_o,
    output logic             intr_overflow_o,
    output logic             intr_quota_o
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------
    pmu_cfg_t      cfg;
    xbar_cfg_t     xbar_cfg;
    pmu_cnt_wr_t   cnt_wr;
    pmu_cnt_vec_t  ovf_mask;
    pmu_cnt_vec_t  quota_mask;
    pmu_word_t     quota_limit;
    pmu_cnt_vec_t  cnt_events;
    pmu_cnt_bank_t counts;
    pmu_cnt_vec_t  wrap;
    pmu_cnt_vec_t  ovf_vect;

    // Software view and configuration
    pmu_regbank u_regbank (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .reg_wr_i      (reg_wr_i),
        .rd_addr_i     (rd_addr_i),
        .counts_i      (counts),
        .ovf_vect_i    (ovf_vect),
        .rd_data_o     (rd_data_o),
        .cfg_o         (cfg),
        .xbar_cfg_o    (xbar_cfg),
        .cnt_wr_o      (cnt_wr),
        .ovf_mask_o    (ovf_mask),
        .quota_mask_o  (quota_mask),
        .quota_limit_o (quota_limit)
    );

    // SoC events to counter events
    pmu_event_xbar u_event_xbar (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events_i),
        .xbar_cfg_i   (xbar_cfg),
        .selftest_i   (cfg.selftest),
        .cnt_events_o (cnt_events)
    );

    pmu_counters u_counters (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (cfg.cnt_en),
        .softrst_i    (cfg.cnt_softrst),
        .cnt_wr_i     (cnt_wr),
        .cnt_events_i (cnt_events),
        .counts_o     (counts),
        .wrap_o       (wrap)
    );

    pmu_interrupts u_interrupts (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .counts_i        (counts),
        .wrap_i          (wrap),
        .ovf_en_i        (cfg.ovf_en),
        .ovf_softrst_i   (cfg.ovf_softrst),
        .ovf_mask_i      (ovf_mask),
        .quota_softrst_i (cfg.quota_softrst),
        .quota_mask_i    (quota_mask),
        .quota_limit_i   (quota_limit),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

`default_nettype wire

/* verif/pmu_checker.sv */
/*
 * Checker of the monitoring unit
 * Cycle model of registers, crossbar, counters and interrupts
 * Compares read data and both interrupts at every rising edge
 */

`default_nettype none

module pmu_checker import pmu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire pmu_reg_wr_t reg_wr_i,
    input  wire pmu_addr_t   rd_addr_i,
    input  wire pmu_events_t events_i,
    input  wire pmu_word_t   rd_data_i,
    input  wire logic        intr_overflow_i,
    input  wire logic        intr_quota_i,
    output int               errors_o,
    output int               checks_o
);

    // Model state
    pmu_word_t              m_cfg;
    pmu_word_t              m_ovf_mask;
    pmu_word_t              m_quota_mask;
    pmu_word_t              m_quota_limit;
    logic [2*REG_WIDTH-1:0] m_xbar;
    pmu_word_t              m_cnt [N_COUNTERS];
    pmu_cnt_vec_t           m_xbar_q;
    pmu_cnt_vec_t           m_ovf_vect;
    logic                   m_quota_intr;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    // Register view as software sees it
    function automatic pmu_word_t expected_read(input pmu_addr_t addr);
        pmu_word_t v;
        v = '0;
        if (addr == ADDR_CFG)
            v = m_cfg;
        else if (addr >= ADDR_CNT_BASE && addr < ADDR_CNT_BASE + N_COUNTERS)
            v = m_cnt[addr - ADDR_CNT_BASE];
        else if (addr == ADDR_OVF_MASK)
            v = m_ovf_mask;
        else if (addr == ADDR_OVF_VECT)
            v = pmu_word_t'(m_ovf_vect);
        else if (addr == ADDR_QUOTA_MASK)
            v = m_quota_mask;
        else if (addr == ADDR_QUOTA_LIMIT)
            v = m_quota_limit;
        else if (addr == ADDR_XBAR_BASE)
            v = m_xbar[REG_WIDTH-1:0];
        else if (addr == ADDR_XBAR_BASE + 1)
            v = m_xbar[2*REG_WIDTH-1:REG_WIDTH];
        return v;
    endfunction

    task automatic compare_value(input string name, input pmu_word_t exp, input pmu_word_t act);
        checks_o++;
        if (act !== exp) begin
            errors_o++;
            $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // One model step per edge, all from pre-edge state
    // ------------------------------------------------------------
    always @(posedge clk_i) begin : model_step
        pmu_cnt_vec_t      ev;
        pmu_cnt_vec_t      wrap;
        pmu_cnt_vec_t      wr_hit;
        longint unsigned   sum;
        if (!rstn_i) begin
            m_cfg         = '0;
            m_ovf_mask    = '0;
            m_quota_mask  = '0;
            m_quota_limit = '0;
            m_xbar        = '0;
            m_xbar_q      = '0;
            m_ovf_vect    = '0;
            m_quota_intr  = 1'b0;
            for (int k = 0; k < N_COUNTERS; k++) begin
                m_cnt[k] = '0;
            end
        end else begin
            compare_value("rd_data_o", expected_read(rd_addr_i), rd_data_i);
            compare_value("intr_overflow_o", pmu_word_t'(|m_ovf_vect),
                          pmu_word_t'(intr_overflow_i));
            compare_value("intr_quota_o", pmu_word_t'(m_quota_intr), pmu_word_t'(intr_quota_i));

            // Self-test overrides the registered crossbar
            case (selftest_e'(m_cfg[CFG_SELFTEST_LSB +: 2]))
                ST_ALL_ON:  ev = '1;
                ST_ALL_OFF: ev = '0;
                ST_ONE_ON:  ev = pmu_cnt_vec_t'(1);
                default:    ev = m_xbar_q;
            endcase

            sum = 0;
            for (int k = 0; k < N_COUNTERS; k++) begin
                wr_hit[k] = reg_wr_i.we && (reg_wr_i.addr == ADDR_CNT_BASE + k);
                // Wrap counts only when the increment wins
                wrap[k] = m_cfg[CFG_CNT_EN_BIT] && ev[k] && !m_cfg[CFG_CNT_SOFTRST_BIT]
                       && !wr_hit[k] && (m_cnt[k] == '1);
                if (m_quota_mask[k])
                    sum = sum + m_cnt[k];
            end

            // Sticky quota flag
            if (m_cfg[CFG_QUOTA_SOFTRST_BIT])
                m_quota_intr = 1'b0;
            else if (sum > m_quota_limit)
                m_quota_intr = 1'b1;

            // Sticky overflow vector
            if (m_cfg[CFG_OVF_SOFTRST_BIT])
                m_ovf_vect = '0;
            else if (m_cfg[CFG_OVF_EN_BIT])
                m_ovf_vect = m_ovf_vect | (wrap & m_ovf_mask[N_COUNTERS-1:0]);

            for (int k = 0; k < N_COUNTERS; k++) begin
                if (m_cfg[CFG_CNT_SOFTRST_BIT])
                    m_cnt[k] = '0;
                else if (wr_hit[k])
                    m_cnt[k] = reg_wr_i.data;
                else if (m_cfg[CFG_CNT_EN_BIT] && ev[k])
                    m_cnt[k] = m_cnt[k] + 32'd1;
                // Crossbar register, one cycle behind events_i
                m_xbar_q[k] = events_i[m_xbar[XBAR_SEL_W*k +: XBAR_SEL_W]];
            end

            // Register writes land last, the step above used old values
            if (reg_wr_i.we) begin
                case (reg_wr_i.addr)
                    ADDR_CFG:           m_cfg         = reg_wr_i.data;
                    ADDR_OVF_MASK:      m_ovf_mask    = reg_wr_i.data;
                    ADDR_QUOTA_MASK:    m_quota_mask  = reg_wr_i.data;
                    ADDR_QUOTA_LIMIT:   m_quota_limit = reg_wr_i.data;
                    ADDR_XBAR_BASE:     m_xbar[REG_WIDTH-1:0] = reg_wr_i.data;
                    ADDR_XBAR_BASE + 1: m_xbar[2*REG_WIDTH-1:REG_WIDTH] = reg_wr_i.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verif/pmu_tb.sv */
/*
 * Testbench of the monitoring unit
 * Clock, reset, random events and register traffic from a fixed seed
 * Directed phases for self-test, overflow and quota, watchdog and report
 */

`default_nettype none

module pmu_tb import pmu_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 400;
    localparam int N_FREEZE     = 20;
    localparam int N_SELFTEST   = 12;
    localparam int N_WRAP       = 24;
    localparam int N_QUOTA_WAIT = 200;
    // Setup writes and sweeps on top of the long phases
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_RANDOM + N_FREEZE
                                + 3 * (N_SELFTEST + N_COUNTERS)
                                + 2 * N_WRAP + N_QUOTA_WAIT + 120;
    localparam int WATCHDOG_MARGIN = 200;

    // Configuration word bits
    localparam pmu_word_t CNT_EN_W    = pmu_word_t'(1) << CFG_CNT_EN_BIT;
    localparam pmu_word_t CNT_RST_W   = pmu_word_t'(1) << CFG_CNT_SOFTRST_BIT;
    localparam pmu_word_t OVF_EN_W    = pmu_word_t'(1) << CFG_OVF_EN_BIT;
    localparam pmu_word_t OVF_RST_W   = pmu_word_t'(1) << CFG_OVF_SOFTRST_BIT;
    localparam pmu_word_t QUOTA_RST_W = pmu_word_t'(1) << CFG_QUOTA_SOFTRST_BIT;

    logic        clk_i;
    logic        rstn_i;
    pmu_reg_wr_t reg_wr_i;
    pmu_addr_t   rd_addr_i;
    pmu_events_t events_i;
    pmu_word_t   rd_data_o;
    logic        intr_overflow_o;
    logic        intr_quota_o;

    integer seed;
    int     tb_errors;
    int     chk_errors;
    int     chk_checks;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    pmu_top pmu_top_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_wr_i        (reg_wr_i),
        .rd_addr_i       (rd_addr_i),
        .events_i        (events_i),
        .rd_data_o       (rd_data_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    pmu_checker u_checker (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_wr_i        (reg_wr_i),
        .rd_addr_i       (rd_addr_i),
        .events_i        (events_i),
        .rd_data_i       (rd_data_o),
        .intr_overflow_i (intr_overflow_o),
        .intr_quota_i    (intr_quota_o),
        .errors_o        (chk_errors),
        .checks_o        (chk_checks)
    );

    // ------------------------------------------------------------
    // Stimulus helpers that change every input on the falling edge
    // ------------------------------------------------------------
    task automatic step(input logic we, input pmu_addr_t addr, input pmu_word_t data);
        @(negedge clk_i);
        reg_wr_i.we   = we;
        reg_wr_i.addr = addr;
        reg_wr_i.data = data;
        events_i      = $random(seed);
        rd_addr_i     = $random(seed);
    endtask

    task automatic write_reg(input int addr, input pmu_word_t data);
        step(1'b1, pmu_addr_t'(addr), data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, '0, '0);
    endtask

    // Occasional writes anywhere but the config word
    task automatic random_cycles(input int n);
        pmu_addr_t a;
        repeat (n) begin
            a = $random(seed);
            if (a == ADDR_CFG)
                a = ADDR_OVF_VECT;
            if (($random(seed) & 7) == 0)
                step(1'b1, a, $random(seed));
            else
                step(1'b0, '0, '0);
        end
    endtask

    // Read each address of the range for one cycle
    task automatic sweep_reads(input int first, input int last);
        for (int a = first; a <= last; a++) begin
            step(1'b0, '0, '0);
            rd_addr_i = pmu_addr_t'(a);
        end
    endtask

    // Counters a few steps below all-ones
    task automatic load_near_wrap();
        for (int k = 0; k < N_COUNTERS; k++) begin
            write_reg(ADDR_CNT_BASE + k, 32'hFFFF_FFF0 | ($random(seed) & 32'h7));
        end
    endtask

    task automatic wait_quota(input int limit_cycles);
        int n;
        n = 0;
        while (!intr_quota_o && n < limit_cycles) begin
            step(1'b0, '0, '0);
            n++;
        end
        if (!intr_quota_o) begin
            tb_errors++;
            $display("Quota interrupt did not rise within %0d cycles", limit_cycles);
        end
    endtask

    function automatic pmu_word_t selftest_word(input selftest_e mode);
        return pmu_word_t'(mode) << CFG_SELFTEST_LSB;
    endfunction

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed      = 61;
        tb_errors = 0;
        rstn_i    = 1'b0;
        reg_wr_i  = '0;
        rd_addr_i = '0;
        events_i  = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        // Everything reads back zero after reset
        sweep_reads(0, 15);

        // Counting through a random crossbar and then frozen counts
        write_reg(ADDR_XBAR_BASE, $random(seed));
        write_reg(ADDR_XBAR_BASE + 1, $random(seed));
        write_reg(ADDR_CFG, CNT_EN_W);
        random_cycles(N_RANDOM);
        write_reg(ADDR_CFG, '0);
        random_cycles(N_FREEZE);

        // Self-test patterns read back per counter and a counter soft reset
        for (int m = 1; m < 4; m++) begin
            write_reg(ADDR_CFG, CNT_EN_W | selftest_word(selftest_e'(m)));
            idle_cycles(N_SELFTEST);
            sweep_reads(ADDR_CNT_BASE, ADDR_CNT_BASE + N_COUNTERS - 1);
        end
        write_reg(ADDR_CFG, CNT_RST_W);
        sweep_reads(ADDR_CNT_BASE, ADDR_CNT_BASE + N_COUNTERS - 1);

        // Overflow with the enable on and again with it off
        write_reg(ADDR_CFG, '0);
        write_reg(ADDR_OVF_MASK, $random(seed) | 32'h1);
        load_near_wrap();
        write_reg(ADDR_CFG, CNT_EN_W | OVF_EN_W | selftest_word(ST_ALL_ON));
        idle_cycles(N_WRAP);
        sweep_reads(ADDR_OVF_VECT, ADDR_OVF_VECT);
        write_reg(ADDR_CFG, OVF_RST_W);
        idle_cycles(2);
        write_reg(ADDR_CFG, '0);
        load_near_wrap();
        write_reg(ADDR_CFG, CNT_EN_W | selftest_word(ST_ALL_ON));
        idle_cycles(N_WRAP);
        sweep_reads(ADDR_OVF_VECT, ADDR_OVF_VECT);

        // Quota crossing and a flag that holds over a counter clear
        write_reg(ADDR_CFG, CNT_RST_W | QUOTA_RST_W);
        write_reg(ADDR_QUOTA_MASK, $random(seed) | 32'h1);
        write_reg(ADDR_QUOTA_LIMIT, 32'd40 + ($random(seed) & 32'h1F));
        write_reg(ADDR_CFG, CNT_EN_W | selftest_word(ST_ALL_ON));
        wait_quota(N_QUOTA_WAIT);
        idle_cycles(4);
        write_reg(ADDR_CFG, CNT_RST_W);
        idle_cycles(4);
        if (!intr_quota_o) begin
            tb_errors++;
            $display("Quota interrupt dropped after the counters were cleared");
        end
        write_reg(ADDR_CFG, QUOTA_RST_W);
        idle_cycles(4);

        $display("checks=%0d errors=%0d", chk_checks, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the planned cycle count
    initial begin
        #((TOTAL_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("checks=%0d errors=%0d", chk_checks, chk_errors + tb_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/pmu_pkg.sv
rtl/pmu_regbank.sv
rtl/pmu_event_xbar.sv
rtl/pmu_counters.sv
rtl/pmu_interrupts.sv
rtl/pmu_top.sv
verif/pmu_checker.sv
verif/pmu_tb.sv

/* Bender.yml */
package:
  name: pmu

sources:
  - rtl/pmu_pkg.sv
  - rtl/pmu_regbank.sv
  - rtl/pmu_event_xbar.sv
  - rtl/pmu_counters.sv
  - rtl/pmu_interrupts.sv
  - rtl/pmu_top.sv
  - target: test
    files:
      - verif/pmu_checker.sv
      - verif/pmu_tb.sv
